// ==== hw/alu.sv ====
module alu (
  input  rv32i_pkg::word_t   a,
  input  rv32i_pkg::word_t   b,
  input  rv32i_pkg::alu_op_t op,
  output rv32i_pkg::word_t   result
);

  always_comb
  begin
    case (op)
      rv32i_pkg::alu_add:
        result = a + b;
      rv32i_pkg::alu_sub:
        result = a - b;
      rv32i_pkg::alu_and:
        result = a & b;
      rv32i_pkg::alu_or:
        result = a | b;
      rv32i_pkg::alu_xor:
        result = a ^ b;
      rv32i_pkg::alu_sll:
        result = a << b[4:0];  // only low five bits shift
      default:
        result = a + b;
    endcase
  end

endmodule

// ==== hw/branch_compare.sv ====
module branch_compare (
  input  rv32i_pkg::word_t a,
  input  rv32i_pkg::word_t b,
  input  logic [2:0]       funct3,
  input  logic             branch,
  output logic             taken
);

  rv32i_pkg::word_t diff;
  logic             carry;  // set when a >= b unsigned
  logic             zero;
  logic             neg;
  logic             ovf;
  logic             cond;

  // a - b as a + ~b + 1
  assign {carry, diff} = {1'b0, a} + {1'b0, ~b} + 33'd1;
  assign zero = (diff == '0);
  assign neg  = diff[31];
  assign ovf  = (a[31] != b[31]) && (diff[31] != a[31]);

  always_comb
  begin
    case (funct3)
      rv32i_pkg::f3_beq:  cond = zero;
      rv32i_pkg::f3_bne:  cond = ~zero;
      rv32i_pkg::f3_blt:  cond = neg != ovf;
      rv32i_pkg::f3_bge:  cond = neg == ovf;
      rv32i_pkg::f3_bltu: cond = ~carry;
      rv32i_pkg::f3_bgeu: cond = carry;
      default:            cond = 1'b0;
    endcase
  end

  assign taken = branch & cond;

endmodule

// ==== hw/decode_stage.sv ====
module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  rv32i_pkg::word_t     fd_inst,
  input  rv32i_pkg::word_t     fd_pc,
  input  logic                 flush,
  output rv32i_pkg::reg_addr_t rs1_addr,
  output rv32i_pkg::reg_addr_t rs2_addr,
  input  rv32i_pkg::word_t     rs1_rdata,
  input  rv32i_pkg::word_t     rs2_rdata,
  output rv32i_pkg::word_t     de_pc,
  output rv32i_pkg::word_t     de_imm,
  output rv32i_pkg::word_t     de_rs1_data,
  output rv32i_pkg::word_t     de_rs2_data,
  output rv32i_pkg::reg_addr_t de_rs1,
  output rv32i_pkg::reg_addr_t de_rs2,
  output rv32i_pkg::reg_addr_t de_rd,
  output rv32i_pkg::alu_op_t   de_alu_op,
  output logic [2:0]           de_funct3,
  output logic                 de_reg_write,
  output logic                 de_mem_write,
  output logic                 de_branch,
  output logic                 de_jal,
  output logic                 de_use_imm,
  output logic                 de_use_pc,
  output logic                 de_zero_a
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic               funct7_5;
  rv32i_pkg::word_t   imm;
  rv32i_pkg::alu_op_t alu_op;
  logic               reg_write;
  logic               mem_write;
  logic               branch;
  logic               jal;
  logic               use_imm;
  logic               use_pc;
  logic               zero_a;

  assign opcode   = fd_inst[6:0];
  assign funct3   = fd_inst[14:12];
  assign funct7_5 = fd_inst[30];  // sub vs add
  assign rs1_addr = fd_inst[19:15];
  assign rs2_addr = fd_inst[24:20];

  // controls, alu op and immediate format in one pass
  always_comb
  begin
    imm       = {{20{fd_inst[31]}}, fd_inst[31:20]};  // I format unless overridden
    alu_op    = rv32i_pkg::alu_add;
    reg_write = 1'b0;
    mem_write = 1'b0;
    branch    = 1'b0;
    jal       = 1'b0;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    zero_a    = 1'b0;
    case (opcode)
      rv32i_pkg::op_r:
      begin
        reg_write = 1'b1;
        case (funct3)
          3'b000:  alu_op = funct7_5 ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
          3'b111:  alu_op = rv32i_pkg::alu_and;
          3'b110:  alu_op = rv32i_pkg::alu_or;
          3'b100:  alu_op = rv32i_pkg::alu_xor;
          default: alu_op = rv32i_pkg::alu_add;
        endcase
      end
      rv32i_pkg::op_i_arith:
      begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        case (funct3)
          3'b001:  alu_op = rv32i_pkg::alu_sll;  // slli, shamt in imm[4:0]
          3'b111:  alu_op = rv32i_pkg::alu_and;
          3'b110:  alu_op = rv32i_pkg::alu_or;
          3'b100:  alu_op = rv32i_pkg::alu_xor;
          default: alu_op = rv32i_pkg::alu_add;
        endcase
      end
      rv32i_pkg::op_store:
      begin
        mem_write = 1'b1;
        use_imm   = 1'b1;
        imm       = {{20{fd_inst[31]}}, fd_inst[31:25], fd_inst[11:7]};
      end
      rv32i_pkg::op_branch:
      begin
        branch = 1'b1;
        imm    = {{19{fd_inst[31]}}, fd_inst[31], fd_inst[7], fd_inst[30:25],
                  fd_inst[11:8], 1'b0};
      end
      rv32i_pkg::op_lui:
      begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        zero_a    = 1'b1;  // 0 + upper imm
        imm       = {fd_inst[31:12], 12'b0};
      end
      rv32i_pkg::op_auipc:
      begin
        reg_write = 1'b1;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        imm       = {fd_inst[31:12], 12'b0};
      end
      rv32i_pkg::op_jal:
      begin
        reg_write = 1'b1;
        jal       = 1'b1;
        imm       = {{11{fd_inst[31]}}, fd_inst[31], fd_inst[19:12], fd_inst[20],
                     fd_inst[30:21], 1'b0};
      end
      default: ;  // unsupported opcode behaves as a bubble
    endcase
  end

  // decode/execute controls, bubble on flush
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset || flush)
    begin
      de_rd        <= '0;
      de_alu_op    <= rv32i_pkg::alu_add;
      de_reg_write <= 1'b0;
      de_mem_write <= 1'b0;
      de_branch    <= 1'b0;
      de_jal       <= 1'b0;
      de_use_imm   <= 1'b0;
      de_use_pc    <= 1'b0;
      de_zero_a    <= 1'b0;
    end
    else
    begin
      de_rd        <= fd_inst[11:7];
      de_alu_op    <= alu_op;
      de_reg_write <= reg_write;
      de_mem_write <= mem_write;
      de_branch    <= branch;
      de_jal       <= jal;
      de_use_imm   <= use_imm;
      de_use_pc    <= use_pc;
      de_zero_a    <= zero_a;
    end
  end

  always_ff @(posedge clk)
  begin
    de_pc       <= fd_pc;
    de_imm      <= imm;
    de_rs1_data <= rs1_rdata;
    de_rs2_data <= rs2_rdata;
    de_rs1      <= rs1_addr;
    de_rs2      <= rs2_addr;
    de_funct3   <= funct3;
  end

endmodule

// ==== hw/execute_stage.sv ====
module execute_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  rv32i_pkg::word_t     de_pc,
  input  rv32i_pkg::word_t     de_imm,
  input  rv32i_pkg::word_t     de_rs1_data,
  input  rv32i_pkg::word_t     de_rs2_data,
  input  rv32i_pkg::reg_addr_t de_rs1,
  input  rv32i_pkg::reg_addr_t de_rs2,
  input  rv32i_pkg::reg_addr_t de_rd,
  input  rv32i_pkg::alu_op_t   de_alu_op,
  input  logic [2:0]           de_funct3,
  input  logic                 de_reg_write,
  input  logic                 de_mem_write,
  input  logic                 de_branch,
  input  logic                 de_jal,
  input  logic                 de_use_imm,
  input  logic                 de_use_pc,
  input  logic                 de_zero_a,
  input  logic                 mem_fwd_we,
  input  logic                 wb_fwd_we,
  input  rv32i_pkg::reg_addr_t mem_fwd_rd,
  input  rv32i_pkg::reg_addr_t wb_fwd_rd,
  input  rv32i_pkg::word_t     mem_fwd_data,
  input  rv32i_pkg::word_t     wb_fwd_data,
  output logic                 redirect,
  output rv32i_pkg::word_t     redirect_target,
  output rv32i_pkg::word_t     em_result,
  output rv32i_pkg::word_t     em_store_data,
  output rv32i_pkg::word_t     em_link,
  output rv32i_pkg::reg_addr_t em_rd,
  output logic                 em_reg_write,
  output logic                 em_mem_write,
  output logic                 em_jal
);

  rv32i_pkg::word_t fwd_a;
  rv32i_pkg::word_t fwd_b;
  rv32i_pkg::word_t op_a;
  rv32i_pkg::word_t op_b;
  rv32i_pkg::word_t alu_result;
  logic             taken;

  // youngest producer first
  always_comb
  begin
    if (de_rs1 != 5'd0 && mem_fwd_we && mem_fwd_rd == de_rs1)
      fwd_a = mem_fwd_data;
    else if (de_rs1 != 5'd0 && wb_fwd_we && wb_fwd_rd == de_rs1)
      fwd_a = wb_fwd_data;
    else
      fwd_a = de_rs1_data;
  end

  always_comb
  begin
    if (de_rs2 != 5'd0 && mem_fwd_we && mem_fwd_rd == de_rs2)
      fwd_b = mem_fwd_data;
    else if (de_rs2 != 5'd0 && wb_fwd_we && wb_fwd_rd == de_rs2)
      fwd_b = wb_fwd_data;
    else
      fwd_b = de_rs2_data;
  end

  assign op_a = de_use_pc ? de_pc : (de_zero_a ? '0 : fwd_a);  // auipc / lui
  assign op_b = de_use_imm ? de_imm : fwd_b;

  alu alu_inst (
    .a      (op_a),
    .b      (op_b),
    .op     (de_alu_op),
    .result (alu_result)
  );

  branch_compare branch_compare_inst (
    .a      (fwd_a),
    .b      (fwd_b),
    .funct3 (de_funct3),
    .branch (de_branch),
    .taken  (taken)
  );

  assign redirect        = taken | de_jal;
  assign redirect_target = de_pc + de_imm;  // B and J offsets are both pc relative

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      em_rd        <= '0;
      em_reg_write <= 1'b0;
      em_mem_write <= 1'b0;
      em_jal       <= 1'b0;
    end
    else
    begin
      em_rd        <= de_rd;
      em_reg_write <= de_reg_write;
      em_mem_write <= de_mem_write;
      em_jal       <= de_jal;
    end
  end

  always_ff @(posedge clk)
  begin
    em_result     <= alu_result;
    em_store_data <= fwd_b;  // sw data after forwarding
    em_link       <= de_pc + 32'd4;
  end

endmodule

// ==== hw/fetch_unit.sv ====
module fetch_unit (
  input  logic             clk,
  input  logic             reset,
  input  rv32i_pkg::word_t inst,
  input  logic             redirect,
  input  rv32i_pkg::word_t redirect_target,
  output rv32i_pkg::word_t pc,
  output rv32i_pkg::word_t fd_inst,
  output rv32i_pkg::word_t fd_pc
);

  rv32i_pkg::word_t next_pc;

  // execute wins over sequential fetch
  assign next_pc = redirect ? redirect_target : pc + 32'd4;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc <= '0;
    end
    else
    begin
      pc <= next_pc;
    end
  end

  // fetch/decode register, killed by a redirect
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      fd_inst <= rv32i_pkg::nop_inst;
    else if (redirect)
      fd_inst <= rv32i_pkg::nop_inst;  // wrong-path instruction
    else
      fd_inst <= inst;
  end

  always_ff @(posedge clk)
  begin
    fd_pc <= pc;
  end

endmodule

// ==== hw/reg_file.sv ====
module reg_file (
  input  logic                 clk,
  input  rv32i_pkg::reg_addr_t rs1_addr,
  input  rv32i_pkg::reg_addr_t rs2_addr,
  output rv32i_pkg::word_t     rs1_rdata,
  output rv32i_pkg::word_t     rs2_rdata,
  input  logic                 we,
  input  rv32i_pkg::reg_addr_t wr_addr,
  input  rv32i_pkg::word_t     wr_data
);

  rv32i_pkg::word_t regs [1:31];  // x0 not stored

  // read ports with write-through from writeback
  assign rs1_rdata = (rs1_addr == 5'd0)            ? '0      :
                     (we && (wr_addr == rs1_addr)) ? wr_data : regs[rs1_addr];
  assign rs2_rdata = (rs2_addr == 5'd0)            ? '0      :
                     (we && (wr_addr == rs2_addr)) ? wr_data : regs[rs2_addr];

  always_ff @(posedge clk)
  begin
    if (we && (wr_addr != 5'd0))
    begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

// ==== hw/retire_stage.sv ====
module retire_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  rv32i_pkg::word_t     em_result,
  input  rv32i_pkg::word_t     em_store_data,
  input  rv32i_pkg::word_t     em_link,
  input  rv32i_pkg::reg_addr_t em_rd,
  input  logic                 em_reg_write,
  input  logic                 em_mem_write,
  input  logic                 em_jal,
  output logic                 mem_write,
  output rv32i_pkg::word_t     mem_addr,
  output rv32i_pkg::word_t     mem_wdata,
  output logic                 mem_fwd_we,
  output logic                 wb_fwd_we,
  output rv32i_pkg::reg_addr_t mem_fwd_rd,
  output rv32i_pkg::reg_addr_t wb_fwd_rd,
  output rv32i_pkg::word_t     mem_fwd_data,
  output rv32i_pkg::word_t     wb_fwd_data
);

  // store port, one cycle per sw
  assign mem_write = em_mem_write;
  assign mem_addr  = em_result;   // x0 + offset from the alu
  assign mem_wdata = em_store_data;

  // memory stage result
  assign mem_fwd_data = em_jal ? em_link : em_result;
  assign mem_fwd_rd   = em_rd;
  assign mem_fwd_we   = em_reg_write;

  // memory/writeback register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wb_fwd_we <= 1'b0;
      wb_fwd_rd <= '0;
    end
    else
    begin
      wb_fwd_we <= mem_fwd_we;
      wb_fwd_rd <= mem_fwd_rd;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_fwd_data <= mem_fwd_data;  // also the regfile write data
  end

endmodule

// ==== hw/rv32i_core.sv ====
module rv32i_core (
  input  logic             clk,
  input  logic             reset,
  output rv32i_pkg::word_t pc,
  input  rv32i_pkg::word_t inst,
  output logic             mem_write,
  output rv32i_pkg::word_t mem_addr,
  output rv32i_pkg::word_t mem_wdata
);

  // fetch -> decode
  rv32i_pkg::word_t     fd_inst;
  rv32i_pkg::word_t     fd_pc;

  // register file read side
  rv32i_pkg::reg_addr_t rs1_addr;
  rv32i_pkg::reg_addr_t rs2_addr;
  rv32i_pkg::word_t     rs1_rdata;
  rv32i_pkg::word_t     rs2_rdata;

  // decode -> execute
  rv32i_pkg::word_t     de_pc;
  rv32i_pkg::word_t     de_imm;
  rv32i_pkg::word_t     de_rs1_data;
  rv32i_pkg::word_t     de_rs2_data;
  rv32i_pkg::reg_addr_t de_rs1;
  rv32i_pkg::reg_addr_t de_rs2;
  rv32i_pkg::reg_addr_t de_rd;
  rv32i_pkg::alu_op_t   de_alu_op;
  logic [2:0]           de_funct3;
  logic                 de_reg_write;
  logic                 de_mem_write;
  logic                 de_branch;
  logic                 de_jal;
  logic                 de_use_imm;
  logic                 de_use_pc;
  logic                 de_zero_a;

  // execute -> fetch
  logic                 redirect;
  rv32i_pkg::word_t     redirect_target;

  // execute -> retire
  rv32i_pkg::word_t     em_result;
  rv32i_pkg::word_t     em_store_data;
  rv32i_pkg::word_t     em_link;
  rv32i_pkg::reg_addr_t em_rd;
  logic                 em_reg_write;
  logic                 em_mem_write;
  logic                 em_jal;

  // forwarding and writeback
  logic                 mem_fwd_we;
  logic                 wb_fwd_we;
  rv32i_pkg::reg_addr_t mem_fwd_rd;
  rv32i_pkg::reg_addr_t wb_fwd_rd;
  rv32i_pkg::word_t     mem_fwd_data;
  rv32i_pkg::word_t     wb_fwd_data;

  fetch_unit fetch_unit_inst (.*);

  decode_stage decode_stage_inst (
    .flush (redirect),  // taken branch or jal in execute
    .*
  );

  reg_file reg_file_inst (
    .clk       (clk),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rs1_rdata (rs1_rdata),
    .rs2_rdata (rs2_rdata),
    .we        (wb_fwd_we),
    .wr_addr   (wb_fwd_rd),
    .wr_data   (wb_fwd_data)
  );

  execute_stage execute_stage_inst (.*);

  retire_stage retire_stage_inst (.*);

endmodule

// ==== hw/rv32i_pkg.sv ====
package rv32i_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;   // data word or byte address
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      alu_op_t;

  // alu operations
  localparam alu_op_t alu_add = 4'd0;
  localparam alu_op_t alu_sub = 4'd1;
  localparam alu_op_t alu_and = 4'd2;
  localparam alu_op_t alu_or  = 4'd3;
  localparam alu_op_t alu_xor = 4'd4;
  localparam alu_op_t alu_sll = 4'd5;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_r       = 7'b0110011;
  localparam logic [6:0] op_i_arith = 7'b0010011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_jal     = 7'b1101111;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // addi x0,x0,0
  localparam word_t nop_inst = 32'h0000_0013;

endpackage

// ==== rv32i_lite.f ====
hw/rv32i_pkg.sv
hw/alu.sv
hw/branch_compare.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/retire_stage.sv
hw/rv32i_core.sv
testbench/store_checker.sv
testbench/tb_top.sv

// ==== testbench/store_checker.sv ====
module store_checker #(
  parameter int prog_len = 64
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   mem_write,
  input  rv32i_pkg::word_t       mem_addr,
  input  rv32i_pkg::word_t       mem_wdata,
  input  logic [prog_len*32-1:0] program_words,
  output logic                   done
);
  timeunit 1ns;
  timeprecision 1ps;

  rv32i_pkg::word_t exp_addr [$];
  rv32i_pkg::word_t exp_data [$];
  int               exp_idx;
  int               errors;

  initial
  begin
    done    = 1'b0;
    exp_idx = 0;
    errors  = 0;
  end

  // ISA model, walks the program from pc 0 up to jal x0,0
  task automatic load_expected();
    rv32i_pkg::word_t x [0:31];
    rv32i_pkg::word_t pc;
    rv32i_pkg::word_t w;
    rv32i_pkg::word_t a;
    rv32i_pkg::word_t b;
    rv32i_pkg::word_t res;
    rv32i_pkg::word_t imm_i;
    rv32i_pkg::word_t imm_s;
    rv32i_pkg::word_t imm_b;
    rv32i_pkg::word_t imm_u;
    rv32i_pkg::word_t imm_j;
    rv32i_pkg::word_t next_pc;
    logic [2:0]       f3;
    logic [4:0]       rd;
    logic             wr;
    logic             halted;
    int               steps;
    exp_addr.delete();
    exp_data.delete();
    exp_idx = 0;
    done    = 1'b0;
    for (int k = 0; k < 32; k++)
      x[k] = '0;
    pc     = '0;
    halted = 1'b0;
    steps  = 0;
    while (!halted && steps < 1000)
    begin
      if (pc[31:2] < prog_len)
        w = program_words[pc[31:2]*32 +: 32];
      else
        w = rv32i_pkg::nop_inst;  // past the end
      f3    = w[14:12];
      rd    = w[11:7];
      a     = x[w[19:15]];
      b     = x[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_u = {w[31:12], 12'b0};
      imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      next_pc = pc + 32'd4;
      wr      = 1'b0;
      res     = '0;
      case (w[6:0])
        rv32i_pkg::op_r:
        begin
          wr = 1'b1;
          case (f3)
            3'b000:  res = w[30] ? a - b : a + b;
            3'b111:  res = a & b;
            3'b110:  res = a | b;
            default: res = a ^ b;
          endcase
        end
        rv32i_pkg::op_i_arith:
        begin
          wr = 1'b1;
          case (f3)
            3'b001:  res = a << w[24:20];
            3'b111:  res = a & imm_i;
            3'b110:  res = a | imm_i;
            3'b100:  res = a ^ imm_i;
            default: res = a + imm_i;
          endcase
        end
        rv32i_pkg::op_store:
        begin
          exp_addr.push_back(a + imm_s);
          exp_data.push_back(b);
        end
        rv32i_pkg::op_branch:
        begin
          case (f3)
            rv32i_pkg::f3_beq:  wr = (a == b);
            rv32i_pkg::f3_bne:  wr = (a != b);
            rv32i_pkg::f3_blt:  wr = ($signed(a) < $signed(b));
            rv32i_pkg::f3_bge:  wr = ($signed(a) >= $signed(b));
            rv32i_pkg::f3_bltu: wr = (a < b);
            default:            wr = (a >= b);
          endcase
          if (wr)
            next_pc = pc + imm_b;
          wr = 1'b0;  // branch condition only, no register write
        end
        rv32i_pkg::op_lui:
        begin
          wr  = 1'b1;
          res = imm_u;
        end
        rv32i_pkg::op_auipc:
        begin
          wr  = 1'b1;
          res = pc + imm_u;
        end
        rv32i_pkg::op_jal:
        begin
          if (imm_j == '0)
            halted = 1'b1;
          wr      = 1'b1;
          res     = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        default: ;
      endcase
      if (wr && rd != 5'd0)
        x[rd] = res;
      pc = next_pc;
      steps++;
    end
    if (!halted)
    begin
      $display("model did not reach the halt within 1000 instructions");
      errors++;
    end
  endtask

  // store port sampled mid-cycle
  always @(negedge clk)
  begin
    if (!reset && mem_write)
    begin
      if (exp_idx >= exp_addr.size())
      begin
        $display("extra store at %0d ns to address %h that the model never makes", $time,
                 mem_addr);
        errors++;
      end
      else
      begin
        if (mem_addr !== exp_addr[exp_idx] || mem_wdata !== exp_data[exp_idx])
        begin
          $display("error at %0d ns: store %0d expected addr %h data %h, got addr %h data %h",
                   $time, exp_idx, exp_addr[exp_idx], exp_data[exp_idx], mem_addr, mem_wdata);
          errors++;
        end
        exp_idx++;
        if (exp_idx == exp_addr.size())
          done = 1'b1;  // last expected store seen
      end
    end
  end

  // errors seen after this call count toward the next test
  task automatic finish_test(output int errs);
    if (exp_idx < exp_addr.size())
    begin
      $display("missing stores, only %0d of %0d expected stores appeared", exp_idx,
               exp_addr.size());
      errors++;
    end
    errs   = errors;
    errors = 0;
  endtask

endmodule

// ==== testbench/tb_top.sv ====
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] seed             = 32'h6aa1;
  localparam int          prog_len         = 64;
  localparam int          num_tests        = 5;
  localparam int          clk_period       = 4;
  localparam int          reset_cycles     = 5;
  localparam int          test_cycle_limit = 180;  // worst path with every branch taken

  logic                   clk;
  logic                   reset;
  rv32i_pkg::word_t       pc;
  rv32i_pkg::word_t       inst;
  logic                   mem_write;
  rv32i_pkg::word_t       mem_addr;
  rv32i_pkg::word_t       mem_wdata;
  logic [prog_len*32-1:0] program_words;
  logic                   test_done;
  logic [31:0]            lfsr_state;
  int                     failed_tests;
  int                     total_errors;

  rv32i_core rv32i_core_inst (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
  );

  store_checker #(
    .prog_len (prog_len)
  ) store_checker_inst (
    .clk           (clk),
    .reset         (reset),
    .mem_write     (mem_write),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .program_words (program_words),
    .done          (test_done)
  );

  // instruction memory, combinational read
  assign inst = (pc[31:2] < prog_len) ? program_words[pc[31:2]*32 +: 32] : rv32i_pkg::nop_inst;

  always #(clk_period / 2) clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic rv32i_pkg::reg_addr_t rand_reg();
    return rv32i_pkg::reg_addr_t'(take_bits(3) % 7 + 1);  // x1..x7
  endfunction

  function automatic rv32i_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv32i_pkg::op_r};
  endfunction

  function automatic rv32i_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv32i_pkg::op_i_arith};
  endfunction

  function automatic rv32i_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv32i_pkg::op_store};  // sw, base x0
  endfunction

  function automatic rv32i_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv32i_pkg::op_branch};
  endfunction

  function automatic rv32i_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32i_pkg::op_jal};
  endfunction

  task automatic set_word(input int idx, input rv32i_pkg::word_t w);
    program_words[idx*32 +: 32] = w;
  endtask

  task automatic emit_store(input int idx, input rv32i_pkg::reg_addr_t rs2);
    set_word(idx, enc_s({2'b00, 8'(take_bits(8)), 2'b00}, rs2));  // word aligned
  endtask

  task automatic emit_alu(input int idx, input rv32i_pkg::reg_addr_t rd);
    logic [2:0]           f3;
    rv32i_pkg::reg_addr_t rs1;
    rv32i_pkg::reg_addr_t rs2;
    logic                 sub;
    case (2'(take_bits(2)))
      2'd0:    f3 = 3'b000;
      2'd1:    f3 = 3'b111;
      2'd2:    f3 = 3'b110;
      default: f3 = 3'b100;
    endcase
    rs1 = rand_reg();
    rs2 = rand_reg();
    sub = take_bits(1) != 0 && f3 == 3'b000;
    if (take_bits(1) != 0)
      set_word(idx, enc_r({1'b0, sub, 5'b0}, rs2, rs1, f3, rd));
    else if (take_bits(2) == 0)
      set_word(idx, enc_i({7'b0, 5'(take_bits(5))}, rs1, 3'b001, rd));  // slli
    else
      set_word(idx, enc_i(12'(take_bits(12)), rs1, f3, rd));
  endtask

  task automatic emit_branch(input int idx);
    rv32i_pkg::reg_addr_t rs1;
    rv32i_pkg::reg_addr_t rs2;
    logic [2:0]           f3;
    rs1 = rand_reg();
    rs2 = rand_reg();
    if (take_bits(2) == 0)
      rs2 = rs1;  // force the equal case now and then
    case (take_bits(3) % 6)
      0:       f3 = rv32i_pkg::f3_beq;
      1:       f3 = rv32i_pkg::f3_bne;
      2:       f3 = rv32i_pkg::f3_blt;
      3:       f3 = rv32i_pkg::f3_bge;
      4:       f3 = rv32i_pkg::f3_bltu;
      default: f3 = rv32i_pkg::f3_bgeu;
    endcase
    set_word(idx, enc_b(take_bits(1) != 0 ? 13'd12 : 13'd8, rs2, rs1, f3));
  endtask

  task automatic build_program(input int kind);
    int                   i;
    int                   skip;
    logic [2:0]           pick;
    rv32i_pkg::reg_addr_t rd;
    // x1..x7 seeded first, signed values from addi
    for (int r = 1; r <= 7; r++)
      set_word(r - 1, enc_i(12'(take_bits(12)), 5'd0, 3'b000, 5'(r)));
    i = 7;
    while (i < prog_len - 2)
    begin
      pick = 3'(take_bits(3));
      rd   = rand_reg();
      if (pick < 2)
      begin
        emit_store(i, rd);
        i++;
      end
      else if (kind == 1 && pick < 4)
      begin
        set_word(i, {20'(take_bits(20)), rd,
                     pick == 2 ? rv32i_pkg::op_lui : rv32i_pkg::op_auipc});
        i++;
      end
      else if (kind == 2 && pick >= 5 && i <= prog_len - 5)
      begin
        emit_branch(i);
        i++;
      end
      else if (kind == 3 && pick >= 5 && i <= prog_len - 6)
      begin
        skip = take_bits(1) != 0 ? 2 : 1;
        set_word(i, enc_j(21'((skip + 1) * 4), rd));
        for (int k = 1; k <= skip; k++)
          emit_store(i + k, rand_reg());  // jumped over, never stored
        emit_store(i + skip + 1, rd);
        i = i + skip + 2;
      end
      else if (kind == 4 && pick >= 4 && i <= prog_len - 4)
      begin
        emit_alu(i, rd);
        emit_store(i + 1, rd);  // data from the instruction just before
        i = i + 2;
      end
      else
      begin
        emit_alu(i, rd);
        i++;
      end
    end
    emit_store(prog_len - 2, 5'd1);
    set_word(prog_len - 1, enc_j(21'd0, 5'd0));  // jal x0,0
  endtask

  function automatic string test_name(input int kind);
    case (kind)
      0:       return "alu forwarding";
      1:       return "lui and auipc";
      2:       return "branches";
      3:       return "jal link";
      default: return "store hazards";
    endcase
  endfunction

  initial
  begin
    int errs;
    int cycles;
    clk           = 1'b0;
    reset         = 1'b1;
    lfsr_state    = seed;
    failed_tests  = 0;
    total_errors  = 0;
    program_words = {prog_len{rv32i_pkg::nop_inst}};
    for (int t = 0; t < num_tests; t++)
    begin
      @(posedge clk);
      reset <= 1'b1;
      build_program(t);
      repeat (reset_cycles) @(posedge clk);
      store_checker_inst.load_expected();
      reset <= 1'b0;
      cycles = 0;
      while (!test_done && cycles < test_cycle_limit)
      begin
        @(posedge clk);
        cycles++;
      end
      repeat (4) @(posedge clk);  // one turn of the halt loop
      store_checker_inst.finish_test(errs);
      total_errors = total_errors + errs;
      if (errs != 0)
        failed_tests++;
      $display("test %0d %s: %s, %0d errors after %0d cycles", t + 1, test_name(t),
               errs == 0 ? "pass" : "fail", errs, cycles);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", num_tests,
             num_tests - failed_tests, failed_tests, total_errors);
    if (failed_tests == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #(num_tests * 200 * clk_period);
    $display("watchdog expired after %0d cycles, the run did not finish", num_tests * 200);
    $display("Test failed");
    $finish;
  end

endmodule
